// ==== logic/vision_macros.svh ====
`ifndef VISION_MACROS_SVH
`define VISION_MACROS_SVH

// 1024x768 at 60 Hz, 65 MHz pixel clock
`define H_ACTIVE 1024
`define H_FRONT 24
`define H_SYNC 136
`define H_TOTAL 1344

`define V_ACTIVE 768
`define V_FRONT 3
`define V_SYNC 6
`define V_TOTAL 806

// coordinate counter widths
`define HCOUNT_W 11
`define VCOUNT_W 10

// centroid accumulators, sized for a full frame of masked pixels
`define SUM_W 32
`define CNT_W 20

// request to pixel, matches the frame buffer read path
`define PIXEL_LAT 2

`endif

// ==== logic/vision_pkg.sv ====
`include "vision_macros.svh"

package vision_pkg;

  // raster coordinates
  typedef logic [`HCOUNT_W-1:0] hcount_t;
  typedef logic [`VCOUNT_W-1:0] vcount_t;

  // 565 pixel from the source
  // red 15..11, green 10..5, blue 4..0
  typedef logic [15:0] pixel565_t;

  // display colour, r in 11..8, g in 7..4, b in 3..0
  typedef logic [11:0] rgb444_t;

  // one channel intensity or threshold bound
  typedef logic [3:0] nibble_t;

  // 0 red, 1 green, 2 blue
  typedef logic [1:0] chan_sel_t;

endpackage

// ==== logic/vga_timing.sv ====
`timescale 1ns/10ps
`include "vision_macros.svh"

module vga_timing (
  input  logic                clk_65mhz,
  input  logic                sys_rst,
  output vision_pkg::hcount_t hcount,
  output vision_pkg::vcount_t vcount,
  output logic                blank,
  output logic                hsync,
  output logic                vsync,
  output logic                frame_start
);
  import vision_pkg::*;

  // sync windows, start inclusive, end exclusive
  localparam int HS_START = `H_ACTIVE + `H_FRONT;
  localparam int HS_END = HS_START + `H_SYNC;
  localparam int VS_START = `V_ACTIVE + `V_FRONT;
  localparam int VS_END = VS_START + `V_SYNC;

  hcount_t h_next;
  vcount_t v_next;

  ////////////////////////////////////////////////////////////////////////////
  // next position in the raster
  always_comb begin
    h_next = hcount + 1'b1;
    v_next = vcount;
    if (hcount == `H_TOTAL - 1) begin
      h_next = '0;
      // wrap to the top after the last line
      v_next = (vcount == `V_TOTAL - 1) ? '0 : vcount + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // counters and flags registered together so they stay aligned
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      hcount <= '0;
      vcount <= '0;
      blank <= 1'b0;
      hsync <= 1'b0;
      vsync <= 1'b0;
      // reset lands on (0,0)
      frame_start <= 1'b1;
    end else begin
      hcount <= h_next;
      vcount <= v_next;
      blank <= (h_next >= `H_ACTIVE) || (v_next >= `V_ACTIVE);
      hsync <= (h_next >= HS_START) && (h_next < HS_END);
      // vsync spans whole lines
      vsync <= (v_next >= VS_START) && (v_next < VS_END);
      frame_start <= (h_next == '0) && (v_next == '0);
    end
  end

endmodule

// ==== logic/pixel_threshold.sv ====
`timescale 1ns/10ps
`include "vision_macros.svh"

module pixel_threshold (
  input  logic                    clk_65mhz,
  input  logic                    sys_rst,
  input  vision_pkg::hcount_t     hcount_in,
  input  vision_pkg::vcount_t     vcount_in,
  input  logic                    blank_in,
  input  logic                    hsync_in,
  input  logic                    vsync_in,
  input  logic                    frame_start_in,
  input  vision_pkg::pixel565_t   pixel_in,
  input  vision_pkg::chan_sel_t   chan_sel,
  input  vision_pkg::nibble_t     lower_bound,
  input  vision_pkg::nibble_t     upper_bound,
  output vision_pkg::hcount_t     hcount_out,
  output vision_pkg::vcount_t     vcount_out,
  output logic                    blank_out,
  output logic                    hsync_out,
  output logic                    vsync_out,
  output logic                    frame_start_out,
  output vision_pkg::pixel565_t   pixel_out,
  output logic                    mask
);
  import vision_pkg::*;

  // coordinates plus blank, hsync, vsync, frame_start
  localparam int SB_W = `HCOUNT_W + `VCOUNT_W + 4;

  logic [SB_W-1:0] sb_pipe [`PIXEL_LAT];
  hcount_t         h_d;
  vcount_t         v_d;
  logic            blank_d;
  logic            hsync_d;
  logic            vsync_d;
  logic            fs_d;
  nibble_t         intensity;
  logic            in_range;

  ////////////////////////////////////////////////////////////////////////////
  // sideband waits out the pixel source latency
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      for (int i = 0; i < `PIXEL_LAT; i++) begin
        sb_pipe[i] <= '0;
      end
    end else begin
      sb_pipe[0] <= {hcount_in, vcount_in, blank_in, hsync_in, vsync_in, frame_start_in};
      for (int i = 1; i < `PIXEL_LAT; i++) begin
        sb_pipe[i] <= sb_pipe[i-1];
      end
    end
  end

  // now lined up with pixel_in
  assign {h_d, v_d, blank_d, hsync_d, vsync_d, fs_d} = sb_pipe[`PIXEL_LAT-1];

  // top four bits of the chosen channel
  always_comb begin
    case (chan_sel)
      2'd1: intensity = pixel_in[10:7];
      2'd2: intensity = pixel_in[4:1];
      default: intensity = pixel_in[15:12];
    endcase
  end

  // bounds inclusive on both ends
  assign in_range = (intensity >= lower_bound) && (intensity <= upper_bound);

  ////////////////////////////////////////////////////////////////////////////
  // stage 3 register
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      {hcount_out, vcount_out} <= '0;
      {blank_out, hsync_out, vsync_out, frame_start_out} <= '0;
      mask <= 1'b0;
    end else begin
      hcount_out <= h_d;
      vcount_out <= v_d;
      blank_out <= blank_d;
      hsync_out <= hsync_d;
      vsync_out <= vsync_d;
      frame_start_out <= fs_d;
      // nothing outside the active area counts
      mask <= in_range && !blank_d;
    end
  end

  always_ff @(posedge clk_65mhz) begin
    pixel_out <= pixel_in;
  end

endmodule

// ==== logic/centroid_accum.sv ====
`timescale 1ns/10ps
`include "vision_macros.svh"

module centroid_accum (
  input  logic                clk_65mhz,
  input  logic                sys_rst,
  input  vision_pkg::hcount_t hcount_in,
  input  vision_pkg::vcount_t vcount_in,
  input  logic                mask,
  input  logic                frame_start_in,
  output vision_pkg::hcount_t com_x,
  output vision_pkg::vcount_t com_y,
  output logic                com_valid
);
  import vision_pkg::*;

  localparam int IDX_W = $clog2(`HCOUNT_W);

  // divider FSM
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_DIV_X = 2'd1;
  localparam logic [1:0] ST_DIV_Y = 2'd2;

  logic [`SUM_W-1:0] sum_x;
  logic [`SUM_W-1:0] sum_y;
  logic [`CNT_W-1:0] pix_cnt;
  logic [1:0]        state;
  logic [`SUM_W-1:0] rem;
  logic [`SUM_W-1:0] sum_y_hold;
  logic [`SUM_W-1:0] divisor;
  logic [`SUM_W-1:0] trial;
  logic [`SUM_W-1:0] rem_next;
  logic [IDX_W-1:0]  bit_idx;
  hcount_t           quot;
  hcount_t           quot_next;
  hcount_t           quot_x;
  logic              take;
  logic              div_last;

  ////////////////////////////////////////////////////////////////////////////
  // per-frame sums, (0,0) already belongs to the new frame
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      sum_x <= '0;
      sum_y <= '0;
      pix_cnt <= '0;
    end else if (frame_start_in) begin
      sum_x <= mask ? `SUM_W'(hcount_in) : '0;
      sum_y <= mask ? `SUM_W'(vcount_in) : '0;
      pix_cnt <= `CNT_W'(mask);
    end else if (mask) begin
      sum_x <= sum_x + `SUM_W'(hcount_in);
      sum_y <= sum_y + `SUM_W'(vcount_in);
      pix_cnt <= pix_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // one restoring step, quotient fits the coordinate width
  always_comb begin
    trial = divisor << bit_idx;
    take = (rem >= trial);
    rem_next = take ? rem - trial : rem;
    quot_next = quot;
    if (take) begin
      quot_next[bit_idx] = 1'b1;
    end
    // remainder below divisor, lower bits are all zero
    div_last = (bit_idx == '0) || (rem_next < divisor);
  end

  // x first, then y through the same datapath
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      state <= ST_IDLE;
      com_valid <= 1'b0;
      com_x <= '0;
      com_y <= '0;
    end else begin
      com_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          // empty frame keeps the old centre
          if (frame_start_in && (pix_cnt != '0)) state <= ST_DIV_X;
        end
        ST_DIV_X: begin
          if (div_last) state <= ST_DIV_Y;
        end
        ST_DIV_Y: begin
          if (div_last) begin
            state <= ST_IDLE;
            com_valid <= 1'b1;
            com_x <= quot_x;
            com_y <= quot_next[`VCOUNT_W-1:0];
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // operands, idle tracks the live sums until the snapshot
  always_ff @(posedge clk_65mhz) begin
    case (state)
      ST_IDLE: begin
        rem <= sum_x;
        sum_y_hold <= sum_y;
        divisor <= `SUM_W'(pix_cnt);
        quot <= '0;
        bit_idx <= IDX_W'(`HCOUNT_W - 1);
      end
      ST_DIV_X: begin
        if (div_last) begin
          quot_x <= quot_next;
          rem <= sum_y_hold;
          quot <= '0;
          bit_idx <= IDX_W'(`VCOUNT_W - 1);
        end else begin
          rem <= rem_next;
          quot <= quot_next;
          bit_idx <= bit_idx - 1'b1;
        end
      end
      ST_DIV_Y: begin
        rem <= rem_next;
        quot <= quot_next;
        bit_idx <= bit_idx - 1'b1;
      end
      default: begin
        quot <= '0;
      end
    endcase
  end

endmodule

// ==== logic/overlay_mux.sv ====
`timescale 1ns/10ps

module overlay_mux (
  input  logic                  clk_65mhz,
  input  logic                  sys_rst,
  input  vision_pkg::hcount_t   hcount_in,
  input  vision_pkg::vcount_t   vcount_in,
  input  logic                  blank_in,
  input  logic                  hsync_in,
  input  logic                  vsync_in,
  input  vision_pkg::pixel565_t pixel_in,
  input  logic                  mask,
  input  vision_pkg::hcount_t   com_x,
  input  vision_pkg::vcount_t   com_y,
  input  logic                  view_mask,
  input  logic                  crosshair_en,
  output vision_pkg::nibble_t   vga_r,
  output vision_pkg::nibble_t   vga_g,
  output vision_pkg::nibble_t   vga_b,
  output logic                  vga_hs,
  output logic                  vga_vs
);
  import vision_pkg::*;

  rgb444_t img_color;
  rgb444_t base_color;
  rgb444_t out_color;
  logic    on_cross;

  ////////////////////////////////////////////////////////////////////////////
  // colour selection

  // top four bits of each channel
  assign img_color = {pixel_in[15:12], pixel_in[10:7], pixel_in[4:1]};

  // column or row through the last centre
  assign on_cross = (hcount_in == com_x) || (vcount_in == com_y);

  always_comb begin
    if (view_mask) begin
      base_color = mask ? 12'hFFF : 12'h000;
    end else begin
      base_color = img_color;
    end
    // crosshair wins over either view
    out_color = (crosshair_en && on_cross) ? 12'h0F0 : base_color;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 4 output register
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      vga_r <= '0;
      vga_g <= '0;
      vga_b <= '0;
      // syncs idle high
      vga_hs <= 1'b1;
      vga_vs <= 1'b1;
    end else begin
      vga_r <= blank_in ? '0 : out_color[11:8];
      vga_g <= blank_in ? '0 : out_color[7:4];
      vga_b <= blank_in ? '0 : out_color[3:0];
      // active low on the connector
      vga_hs <= ~hsync_in;
      vga_vs <= ~vsync_in;
    end
  end

endmodule

// ==== logic/vision_overlay_top.sv ====
`timescale 1ns/10ps

module vision_overlay_top (
  input  logic                  clk_65mhz,
  input  logic                  sys_rst,
  input  vision_pkg::pixel565_t pixel_in,
  input  vision_pkg::chan_sel_t chan_sel,
  input  vision_pkg::nibble_t   lower_bound,
  input  vision_pkg::nibble_t   upper_bound,
  input  logic                  view_mask,
  input  logic                  crosshair_en,
  output vision_pkg::hcount_t   req_x,
  output vision_pkg::vcount_t   req_y,
  output vision_pkg::nibble_t   vga_r,
  output vision_pkg::nibble_t   vga_g,
  output vision_pkg::nibble_t   vga_b,
  output logic                  vga_hs,
  output logic                  vga_vs,
  output vision_pkg::hcount_t   com_x,
  output vision_pkg::vcount_t   com_y,
  output logic                  com_valid
);
  import vision_pkg::*;

  // stage 0, raster
  logic      blank;
  logic      hsync;
  logic      vsync;
  logic      frame_start;
  // stage 3, threshold output
  hcount_t   th_hcount;
  vcount_t   th_vcount;
  logic      th_blank;
  logic      th_hsync;
  logic      th_vsync;
  logic      th_frame_start;
  pixel565_t th_pixel;
  logic      th_mask;

  ////////////////////////////////////////////////////////////////////////////
  // raster doubles as the pixel request
  vga_timing u_timing (
    .clk_65mhz   (clk_65mhz),
    .sys_rst     (sys_rst),
    .hcount      (req_x),
    .vcount      (req_y),
    .blank       (blank),
    .hsync       (hsync),
    .vsync       (vsync),
    .frame_start (frame_start)
  );

  // pixel comes back two cycles later
  pixel_threshold u_threshold (
    .clk_65mhz       (clk_65mhz),
    .sys_rst         (sys_rst),
    .hcount_in       (req_x),
    .vcount_in       (req_y),
    .blank_in        (blank),
    .hsync_in        (hsync),
    .vsync_in        (vsync),
    .frame_start_in  (frame_start),
    .pixel_in        (pixel_in),
    .chan_sel        (chan_sel),
    .lower_bound     (lower_bound),
    .upper_bound     (upper_bound),
    .hcount_out      (th_hcount),
    .vcount_out      (th_vcount),
    .blank_out       (th_blank),
    .hsync_out       (th_hsync),
    .vsync_out       (th_vsync),
    .frame_start_out (th_frame_start),
    .pixel_out       (th_pixel),
    .mask            (th_mask)
  );

  centroid_accum u_centroid (
    .clk_65mhz      (clk_65mhz),
    .sys_rst        (sys_rst),
    .hcount_in      (th_hcount),
    .vcount_in      (th_vcount),
    .mask           (th_mask),
    .frame_start_in (th_frame_start),
    .com_x          (com_x),
    .com_y          (com_y),
    .com_valid      (com_valid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // final colour and syncs, stage 4
  overlay_mux u_overlay (
    .clk_65mhz    (clk_65mhz),
    .sys_rst      (sys_rst),
    .hcount_in    (th_hcount),
    .vcount_in    (th_vcount),
    .blank_in     (th_blank),
    .hsync_in     (th_hsync),
    .vsync_in     (th_vsync),
    .pixel_in     (th_pixel),
    .mask         (th_mask),
    .com_x        (com_x),
    .com_y        (com_y),
    .view_mask    (view_mask),
    .crosshair_en (crosshair_en),
    .vga_r        (vga_r),
    .vga_g        (vga_g),
    .vga_b        (vga_b),
    .vga_hs       (vga_hs),
    .vga_vs       (vga_vs)
  );

endmodule

// ==== dv/vision_overlay_assertions.sv ====
`timescale 1ns/10ps

module vision_overlay_assertions (
  input logic                clk_65mhz,
  input logic                sys_rst,
  input logic                com_valid,
  input logic                ov_blank,
  input vision_pkg::nibble_t vga_r,
  input vision_pkg::nibble_t vga_g,
  input vision_pkg::nibble_t vga_b,
  input logic                vga_hs
);

  // divider result strobe lasts one cycle
  com_valid_single: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    com_valid |=> !com_valid)
    else $error("com_valid stayed high for more than one cycle");

  // blank at the overlay input, black on the next output
  blank_black: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    ov_blank |=> (vga_r == '0 && vga_g == '0 && vga_b == '0))
    else $error("colour outputs not zero after blank");

  // hsync idles high while reset is held
  hs_idle_in_reset: assert property (@(posedge clk_65mhz) sys_rst |=> vga_hs)
    else $error("vga_hs low during reset");

endmodule

bind vision_overlay_top vision_overlay_assertions u_checks (
  .clk_65mhz (clk_65mhz),
  .sys_rst   (sys_rst),
  .com_valid (com_valid),
  .ov_blank  (th_blank),
  .vga_r     (vga_r),
  .vga_g     (vga_g),
  .vga_b     (vga_b),
  .vga_hs    (vga_hs)
);

// ==== dv/vision_overlay_tb.sv ====
`timescale 1ns/10ps
`include "vision_macros.svh"

module vision_overlay_tb;
  import vision_pkg::*;

  localparam int NUM_ROWS = 4;
  localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
  // four frames plus fifty lines of slack
  localparam int CYCLE_LIMIT = NUM_ROWS * FRAME_CYCLES + 50 * `H_TOTAL;
  localparam int APPLY_LINE = 790;
  localparam int MAX_PRINTS = 20;

  logic      clk_65mhz;
  logic      sys_rst;
  pixel565_t pixel_in;
  chan_sel_t chan_sel;
  nibble_t   lower_bound;
  nibble_t   upper_bound;
  logic      view_mask;
  logic      crosshair_en;
  hcount_t   req_x;
  vcount_t   req_y;
  nibble_t   vga_r;
  nibble_t   vga_g;
  nibble_t   vga_b;
  logic      vga_hs;
  logic      vga_vs;
  hcount_t   com_x;
  vcount_t   com_y;
  logic      com_valid;

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table, one row per frame
  // rectangle x0 y0 x1 y1, rectangle colour, channel, bounds, view, crosshair
  int          row_x0 [NUM_ROWS] = '{100, 400, 10, 700};
  int          row_y0 [NUM_ROWS] = '{50, 300, 600, 20};
  int          row_x1 [NUM_ROWS] = '{299, 551, 1000, 760};
  int          row_y1 [NUM_ROWS] = '{149, 420, 700, 760};
  logic [15:0] row_color [NUM_ROWS] = '{16'hA5E3, 16'h5392, 16'hC828, 16'h6F0F};
  logic [1:0]  row_chan [NUM_ROWS] = '{2'd0, 2'd1, 2'd2, 2'd0};
  logic [3:0]  row_lo [NUM_ROWS] = '{4'h8, 4'h6, 4'h3, 4'h4};
  logic [3:0]  row_hi [NUM_ROWS] = '{4'hF, 4'h9, 4'h5, 4'hC};
  logic        row_view [NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1};
  logic        row_cross [NUM_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b1};

  // reference model state
  int          cur_row = 0;
  logic [15:0] bg_base = '0;
  int          cross_x = -1;
  int          cross_y = -1;
  int          frame_idx = -1;
  int          pulses = 0;
  int          mismatches = 0;
  int          failures = 0;
  int          cycle_count = 0;
  int          hs_low = 0;
  int          vs_low = 0;
  int          hs_last_fall = -1;
  logic        hs_prev = 1'b1;
  bit          done = 1'b0;
  // request coordinates, oldest is on the display
  int          q_x [$];
  int          q_y [$];

  vision_overlay_top DUT (
    .clk_65mhz    (clk_65mhz),
    .sys_rst      (sys_rst),
    .pixel_in     (pixel_in),
    .chan_sel     (chan_sel),
    .lower_bound  (lower_bound),
    .upper_bound  (upper_bound),
    .view_mask    (view_mask),
    .crosshair_en (crosshair_en),
    .req_x        (req_x),
    .req_y        (req_y),
    .vga_r        (vga_r),
    .vga_g        (vga_g),
    .vga_b        (vga_b),
    .vga_hs       (vga_hs),
    .vga_vs       (vga_vs),
    .com_x        (com_x),
    .com_y        (com_y),
    .com_valid    (com_valid)
  );

  initial begin
    clk_65mhz = 1'b0;
    forever #5 clk_65mhz = ~clk_65mhz;
  end

  // frame after the last table row repeats that row
  function automatic int content_row(int f);
    return (f > NUM_ROWS - 1) ? NUM_ROWS - 1 : f;
  endfunction

  function automatic bit in_rect(int row, int x, int y);
    return x >= row_x0[row] && x <= row_x1[row] && y >= row_y0[row] && y <= row_y1[row];
  endfunction

  // source image, rectangle on a patterned background
  function automatic logic [15:0] pixel_for(int row, int x, int y);
    logic [15:0] bg;
    // blanking carries an in-range colour, mask must still stay low there
    if (x >= `H_ACTIVE || y >= `V_ACTIVE) return row_color[row];
    if (in_rect(row, x, y)) return row_color[row];
    bg = bg_base ^ 16'(x * 7 + y * 13);
    // selected channel at zero, below every lower bound
    case (row_chan[row])
      2'd1: bg[10:7] = 4'h0;
      2'd2: bg[4:1] = 4'h0;
      default: bg[15:12] = 4'h0;
    endcase
    return bg;
  endfunction

  function automatic logic [11:0] expected_color(int row, int x, int y);
    logic [15:0] p;
    if (x >= `H_ACTIVE || y >= `V_ACTIVE) return 12'h000;
    if (row_cross[row] && (x == cross_x || y == cross_y)) return 12'h0F0;
    if (row_view[row]) return in_rect(row, x, y) ? 12'hFFF : 12'h000;
    p = pixel_for(row, x, y);
    return {p[15:12], p[10:7], p[4:1]};
  endfunction

  task automatic apply_row(int row);
    cur_row = row;
    bg_base = 16'($urandom);
    chan_sel = row_chan[row];
    lower_bound = row_lo[row];
    upper_bound = row_hi[row];
    view_mask = row_view[row];
    crosshair_en = row_cross[row];
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // per-cycle checks
  task automatic check_colour(int x, int y);
    logic [11:0] exp_c;
    logic [11:0] got;
    exp_c = expected_color(cur_row, x, y);
    got = {vga_r, vga_g, vga_b};
    assert (got == exp_c) else begin
      mismatches++;
      if (mismatches <= MAX_PRINTS)
        $display("MISMATCH t=%0t colour at (%0d,%0d) is %h, expected %h",
                 $time, x, y, got, exp_c);
    end
  endtask

  // connector syncs line up with the displayed coordinate, active low
  task automatic check_sync_level(int x, int y);
    logic exp_hs;
    logic exp_vs;
    exp_hs = !(x >= `H_ACTIVE + `H_FRONT && x < `H_ACTIVE + `H_FRONT + `H_SYNC);
    exp_vs = !(y >= `V_ACTIVE + `V_FRONT && y < `V_ACTIVE + `V_FRONT + `V_SYNC);
    assert (vga_hs == exp_hs && vga_vs == exp_vs) else begin
      mismatches++;
      if (mismatches <= MAX_PRINTS)
        $display("MISMATCH t=%0t syncs at (%0d,%0d) are %b%b, expected %b%b",
                 $time, x, y, vga_hs, vga_vs, exp_hs, exp_vs);
    end
  endtask

  task automatic check_syncs();
    // hsync period, falling edge to falling edge
    if (!vga_hs && hs_prev) begin
      if (hs_last_fall >= 0) begin
        assert (cycle_count - hs_last_fall == `H_TOTAL) else begin
          mismatches++;
          $display("MISMATCH t=%0t hsync period %0d", $time, cycle_count - hs_last_fall);
        end
      end
      hs_last_fall = cycle_count;
    end
    if (!vga_hs) begin
      hs_low++;
    end else begin
      if (hs_low != 0) begin
        assert (hs_low == `H_SYNC) else begin
          mismatches++;
          $display("MISMATCH t=%0t hsync low for %0d cycles", $time, hs_low);
        end
      end
      hs_low = 0;
    end
    // vsync spans whole lines
    if (!vga_vs) begin
      vs_low++;
    end else begin
      if (vs_low != 0) begin
        assert (vs_low == `V_SYNC * `H_TOTAL) else begin
          mismatches++;
          $display("MISMATCH t=%0t vsync low for %0d cycles", $time, vs_low);
        end
      end
      vs_low = 0;
    end
    hs_prev = vga_hs;
  endtask

  task automatic check_centroid();
    int prev;
    prev = (frame_idx >= 1) ? content_row(frame_idx - 1) : -1;
    if (com_valid) begin
      pulses++;
      if (prev < 0) begin
        failures++;
        $display("centroid pulse in the first frame, no frame had finished (t=%0t)", $time);
      end else begin
        assert (int'(com_x) == (row_x0[prev] + row_x1[prev]) / 2 &&
                int'(com_y) == (row_y0[prev] + row_y1[prev]) / 2) else begin
          mismatches++;
          $display("MISMATCH t=%0t centre (%0d,%0d), expected (%0d,%0d)", $time,
                   com_x, com_y, (row_x0[prev] + row_x1[prev]) / 2,
                   (row_y0[prev] + row_y1[prev]) / 2);
        end
      end
    end
    // divider has to be done by line 1
    if (req_x == 0 && req_y == 1) begin
      assert (pulses == ((prev >= 0) ? 1 : 0)) else begin
        failures++;
        $display("frame %0d saw %0d centroid pulses before line 1", frame_idx, pulses);
      end
      pulses = 0;
      if (frame_idx == NUM_ROWS) done = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reset, table and pixel source
  initial begin
    void'($urandom(59634));
    sys_rst = 1'b1;
    pixel_in = '0;
    apply_row(0);
    repeat (3) @(posedge clk_65mhz);
    #1;
    sys_rst = 1'b0;
    while (!done) begin
      q_x.push_back(int'(req_x));
      q_y.push_back(int'(req_y));
      if (req_x == 0 && req_y == 0) begin
        frame_idx++;
        // crosshair follows the frame before
        if (frame_idx >= 1) begin
          cross_x = (row_x0[content_row(frame_idx - 1)] + row_x1[content_row(frame_idx - 1)]) / 2;
          cross_y = (row_y0[content_row(frame_idx - 1)] + row_y1[content_row(frame_idx - 1)]) / 2;
        end
      end
      check_centroid();
      check_syncs();
      // request from two cycles back gets its pixel now
      if (q_x.size() > `PIXEL_LAT)
        pixel_in = pixel_for(cur_row, q_x[q_x.size() - 1 - `PIXEL_LAT],
                             q_y[q_y.size() - 1 - `PIXEL_LAT]);
      // four stages from request to connector
      if (q_x.size() == 5) begin
        check_colour(q_x[0], q_y[0]);
        check_sync_level(q_x[0], q_y[0]);
        void'(q_x.pop_front());
        void'(q_y.pop_front());
      end
      // next row in vertical blanking
      if (req_x == 0 && req_y == APPLY_LINE && cur_row < NUM_ROWS - 1)
        apply_row(cur_row + 1);
      @(posedge clk_65mhz);
      #1;
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // watchdog
  always @(posedge clk_65mhz) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
      $display("Checks failed");
      $finish;
    end
  end

endmodule

// ==== vision_overlay.f ====
+incdir+logic
logic/vision_pkg.sv
logic/vga_timing.sv
logic/pixel_threshold.sv
logic/centroid_accum.sv
logic/overlay_mux.sv
logic/vision_overlay_top.sv
dv/vision_overlay_assertions.sv
dv/vision_overlay_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module vision_overlay_tb \
  -f vision_overlay.f -o vision_overlay_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/vision_overlay_sim > sim.log 2>&1
cat sim.log
grep -qx "All checks passed" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }
